//--- filelist.f
+incdir+logic
logic/gfx_pkg.sv
logic/host_pkg.sv
logic/host_regs.sv
logic/shape_sequencer.sv
logic/rotate_xy.sv
logic/draw_line.sv
logic/framebuffer.sv
logic/shape_engine_top.sv
sim/shape_engine_properties.sv
sim/shape_engine_tb.sv

//--- logic/draw_line.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bresenham line walker, p0 to p1 inclusive, one pixel per accepted
// beat on a valid/ready stream
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module draw_line (
    input  logic             clk_100m,
    input  logic             reset,
    input  logic             start,
    input  gfx_pkg::vertex_t p0,
    input  gfx_pkg::vertex_t p1,
    output gfx_pkg::pixel_t  pix,
    output logic             pix_valid,
    input  logic             pix_ready,
    output logic             done
);
    import gfx_pkg::*;

    logic signed [16:0] abs_dx;     // start values from the ports
    logic signed [16:0] neg_dy;
    logic signed [16:0] dx;
    logic signed [16:0] dy;         // kept negative
    logic signed [17:0] err;
    logic signed [17:0] err_nxt;
    logic signed [18:0] e2;
    logic               step_right;
    logic               step_down;
    coord_t             x_end;
    coord_t             y_end;
    logic               last;

    always_comb begin
        abs_dx  = (p1.x > p0.x) ? p1.x - p0.x : p0.x - p1.x;
        neg_dy  = (p1.y > p0.y) ? p0.y - p1.y : p1.y - p0.y;
        e2      = err + err;
        err_nxt = err;
        if (e2 >= dy)
            err_nxt = err_nxt + dy;
        if (e2 <= dx)
            err_nxt = err_nxt + dx;
        last    = (pix.x == x_end) && (pix.y == y_end);
    end

    always_ff @(posedge clk_100m) begin
        done <= 1'b0;
        if (reset) begin
            pix_valid <= 1'b0;
        end else if (start) begin
            pix        <= pixel_t'(p0);
            x_end      <= p1.x;
            y_end      <= p1.y;
            dx         <= abs_dx;
            dy         <= neg_dy;
            err        <= abs_dx + neg_dy;
            step_right <= p1.x > p0.x;
            step_down  <= p1.y > p0.y;
            pix_valid  <= 1'b1;
        end else if (pix_valid && pix_ready) begin   // only move on a taken beat
            if (last) begin
                pix_valid <= 1'b0;
                done      <= 1'b1;
            end else begin
                err <= err_nxt;
                if (e2 >= dy)
                    pix.x <= step_right ? pix.x + 16'sd1 : pix.x - 16'sd1;
                if (e2 <= dx)
                    pix.y <= step_down ? pix.y + 16'sd1 : pix.y - 16'sd1;
            end
        end
    end

endmodule

//--- logic/framebuffer.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 64x64 colour index memory; write port shared by the clear engine and
// clipped pixel writes, read port serves the host
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module framebuffer (
    input  logic              clk_100m,
    input  logic              reset,
    input  logic              clear,
    input  gfx_pkg::cidx_t    bg,
    input  gfx_pkg::cidx_t    fg,
    output logic              clear_busy,
    input  gfx_pkg::pixel_t   pix,
    input  logic              pix_valid,
    output logic              pix_ready,
    input  gfx_pkg::fb_addr_t rd_addr,
    output gfx_pkg::cidx_t    rd_data
);
    import gfx_pkg::*;

    cidx_t    mem [FB_DEPTH];
    fb_addr_t clr_addr;
    cidx_t    clr_colour;
    logic     on_screen;
    logic     we;
    fb_addr_t wr_addr;
    cidx_t    wr_data;

    assign pix_ready = !clear_busy;   // pixels wait for the clear
    assign on_screen = pix.x >= 0 && pix.x < FB_SIDE && pix.y >= 0 && pix.y < FB_SIDE;

    always_comb begin
        if (clear_busy) begin
            we      = 1'b1;
            wr_addr = clr_addr;
            wr_data = clr_colour;
        end else begin
            we      = pix_valid && on_screen;   // off-screen beats just dropped
            wr_addr = {pix.y[5:0], pix.x[5:0]};
            wr_data = fg;
        end
    end

    always_ff @(posedge clk_100m) begin
        if (reset) begin
            clear_busy <= 1'b0;
        end else if (clear) begin
            clear_busy <= 1'b1;
            clr_addr   <= '0;
            clr_colour <= bg;
        end else if (clear_busy) begin
            clr_addr <= clr_addr + 1'b1;
            if (clr_addr == fb_addr_t'(FB_DEPTH - 1))
                clear_busy <= 1'b0;
        end
    end

    always_ff @(posedge clk_100m) begin
        if (we)
            mem[wr_addr] <= wr_data;
        rd_data <= mem[rd_addr];
    end

endmodule

//--- logic/gfx_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// drawing side types and sizes, shared by the engine datapath and the
// testbench model
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package gfx_pkg;

    localparam int FB_SIDE     = 64;                 // width and height in pixels
    localparam int FB_DEPTH    = FB_SIDE * FB_SIDE;
    localparam int TRIG_SHIFT  = 7;                  // trig values scaled by 127
    localparam int ROT_LATENCY = 3;

    typedef logic signed [15:0] coord_t;
    typedef logic [7:0]         angle_t;             // 256 steps per turn
    typedef logic signed [7:0]  trig_t;
    typedef logic [3:0]         cidx_t;
    typedef logic [11:0]        fb_addr_t;           // y * 64 + x

    // y sits above x so a register word maps straight onto a vertex
    typedef struct packed {
        coord_t y;
        coord_t x;
    } vertex_t;

    // one beat of the pixel stream into the framebuffer
    typedef struct packed {
        coord_t y;
        coord_t x;
    } pixel_t;

endpackage

//--- logic/host_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// host side view: AXI4-Lite channel bundles, register map and the
// draw configuration handed to the sequencer
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package host_pkg;

    typedef logic [15:0] axi_addr_t;
    typedef logic [31:0] axi_data_t;

    typedef struct packed {
        axi_addr_t  awaddr;
        logic       awvalid;
        axi_data_t  wdata;
        logic [3:0] wstrb;
        logic       wvalid;
        logic       bready;
        axi_addr_t  araddr;
        logic       arvalid;
        logic       rready;
    } axil_req_t;

    typedef struct packed {
        logic       awready;
        logic       wready;
        logic [1:0] bresp;
        logic       bvalid;
        logic       arready;
        axi_data_t  rdata;
        logic [1:0] rresp;
        logic       rvalid;
    } axil_rsp_t;

    localparam axi_addr_t REG_CTRL   = 16'h0000;  // bit 0 start
    localparam axi_addr_t REG_STATUS = 16'h0004;  // bit 0 busy, bit 1 done
    localparam axi_addr_t REG_ANGLE  = 16'h0008;
    localparam axi_addr_t REG_OFFSET = 16'h000C;
    localparam axi_addr_t REG_V0     = 16'h0010;
    localparam axi_addr_t REG_V1     = 16'h0014;
    localparam axi_addr_t REG_V2     = 16'h0018;
    localparam axi_addr_t REG_COLOUR = 16'h001C;  // fg in 3:0, bg in 7:4
    localparam axi_addr_t FB_BASE    = 16'h4000;  // one word per pixel

    typedef struct packed {
        gfx_pkg::vertex_t v0;
        gfx_pkg::vertex_t v1;
        gfx_pkg::vertex_t v2;
        gfx_pkg::vertex_t offset;
        gfx_pkg::angle_t  angle;
        gfx_pkg::cidx_t   fg;
        gfx_pkg::cidx_t   bg;
    } draw_cfg_t;

endpackage

//--- logic/host_regs.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI4-Lite slave for the draw configuration, start and status bits,
// plus the read window onto the framebuffer
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module host_regs (
    input  logic                clk_100m,
    input  logic                reset,
    input  host_pkg::axil_req_t axi_req,
    output host_pkg::axil_rsp_t axi_rsp,
    output host_pkg::draw_cfg_t cfg,
    output logic                start,
    input  logic                busy,
    input  logic                done_pulse,
    output logic                irq,
    output gfx_pkg::fb_addr_t   rd_addr,
    input  gfx_pkg::cidx_t      rd_data
);
    import host_pkg::*;

    logic      wr_ready;   // awready and wready together
    logic      bvalid;
    logic      arready;
    logic      rvalid;
    logic      fb_pend;    // framebuffer read in flight
    logic      done_bit;
    logic      ar_fb;
    axi_data_t rdata;
    axi_data_t wr_word;

    function automatic axi_data_t reg_word(input axi_addr_t addr);
        case (addr)
            REG_STATUS: return {30'd0, done_bit, busy};
            REG_ANGLE:  return {24'd0, cfg.angle};
            REG_OFFSET: return cfg.offset;
            REG_V0:     return cfg.v0;
            REG_V1:     return cfg.v1;
            REG_V2:     return cfg.v2;
            REG_COLOUR: return {24'd0, cfg.bg, cfg.fg};
            default:    return '0;  // ctrl and holes read as zero
        endcase
    endfunction

    // byte strobes merge into the current register value
    always_comb begin
        wr_word = reg_word(axi_req.awaddr);
        for (int b = 0; b < 4; b++) begin
            if (axi_req.wstrb[b])
                wr_word[8*b +: 8] = axi_req.wdata[8*b +: 8];
        end
    end

    always_ff @(posedge clk_100m) begin
        start <= 1'b0;
        irq   <= done_pulse;
        if (reset) begin
            wr_ready <= 1'b0;
            bvalid   <= 1'b0;
            done_bit <= 1'b0;
            irq      <= 1'b0;
        end else begin
            wr_ready <= axi_req.awvalid && axi_req.wvalid && !bvalid && !wr_ready;
            if (wr_ready) begin
                bvalid <= 1'b1;
                case (axi_req.awaddr)
                    REG_CTRL:   start      <= wr_word[0] && !busy;  // no restart mid draw
                    REG_ANGLE:  cfg.angle  <= wr_word[7:0];
                    REG_OFFSET: cfg.offset <= wr_word;
                    REG_V0:     cfg.v0     <= wr_word;
                    REG_V1:     cfg.v1     <= wr_word;
                    REG_V2:     cfg.v2     <= wr_word;
                    REG_COLOUR: begin
                        cfg.fg <= wr_word[3:0];
                        cfg.bg <= wr_word[7:4];
                    end
                    default: ;
                endcase
            end else if (axi_req.bready) begin
                bvalid <= 1'b0;
            end
            if (done_pulse)
                done_bit <= 1'b1;
            else if (start)
                done_bit <= 1'b0;
        end
    end

    assign ar_fb   = axi_req.araddr[15:14] == FB_BASE[15:14];
    assign rd_addr = axi_req.araddr[13:2];  // word index inside the window

    // register reads answer next cycle, window reads wait on the memory
    always_ff @(posedge clk_100m) begin
        if (reset) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            fb_pend <= 1'b0;
        end else if (arready && axi_req.arvalid) begin
            arready <= 1'b0;
            fb_pend <= ar_fb;
            rvalid  <= !ar_fb;
            rdata   <= reg_word(axi_req.araddr);
        end else if (fb_pend) begin
            fb_pend <= 1'b0;
            rvalid  <= 1'b1;
            rdata   <= {28'd0, rd_data};
        end else if (rvalid) begin
            rvalid <= !axi_req.rready;
        end else begin
            arready <= 1'b1;
        end
    end

    always_comb begin
        axi_rsp.awready = wr_ready;
        axi_rsp.wready  = wr_ready;
        axi_rsp.bresp   = 2'b00;   // always OKAY
        axi_rsp.bvalid  = bvalid;
        axi_rsp.arready = arready;
        axi_rsp.rdata   = rdata;
        axi_rsp.rresp   = 2'b00;
        axi_rsp.rvalid  = rvalid;
    end

endmodule

//--- logic/rotate_xy.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// rotate a vertex about the origin then translate it, three stage
// pipeline taking a new vertex every cycle
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module rotate_xy (
    input  logic             clk_100m,
    input  logic             reset,
    input  logic             start,
    input  gfx_pkg::vertex_t vin,
    input  gfx_pkg::angle_t  angle,
    input  gfx_pkg::vertex_t offset,
    output gfx_pkg::vertex_t vout,
    output logic             done
);
    import gfx_pkg::*;

    `include "sin_table.svh"

    logic [ROT_LATENCY-1:0] vld;   // one valid bit per stage
    trig_t                  sin1;
    trig_t                  cos1;
    vertex_t                v1;
    vertex_t                off1;
    vertex_t                off2;
    logic signed [23:0]     xc;
    logic signed [23:0]     ys;
    logic signed [23:0]     xs;
    logic signed [23:0]     yc;
    logic signed [24:0]     sum_x;
    logic signed [24:0]     sum_y;

    always_ff @(posedge clk_100m) begin
        if (reset)
            vld <= '0;
        else
            vld <= {vld[ROT_LATENCY-2:0], start};
    end

    always_comb begin
        sum_x = xc - ys;
        sum_y = xs + yc;
    end

    always_ff @(posedge clk_100m) begin
        sin1 <= sin_lookup(angle);
        cos1 <= sin_lookup(angle + 8'd64);   // cos is sin a quarter turn on
        v1   <= vin;
        off1 <= offset;
        xc   <= v1.x * cos1;
        ys   <= v1.y * sin1;
        xs   <= v1.x * sin1;
        yc   <= v1.y * cos1;
        off2 <= off1;
        vout.x <= coord_t'(sum_x >>> TRIG_SHIFT) + off2.x;  // wraps to 16 bits
        vout.y <= coord_t'(sum_y >>> TRIG_SHIFT) + off2.y;
    end

    assign done = vld[ROT_LATENCY-1];

endmodule

//--- logic/shape_engine_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shape engine top: host registers, sequencer and drawing datapath
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module shape_engine_top (
    input  logic                clk_100m,
    input  logic                reset,
    input  host_pkg::axil_req_t axi_req,
    output host_pkg::axil_rsp_t axi_rsp,
    output logic                irq
);
    import gfx_pkg::*;
    import host_pkg::*;

    draw_cfg_t cfg;
    logic      start;
    logic      busy;
    logic      done_pulse;
    fb_addr_t  fb_rd_addr;
    cidx_t     fb_rd_data;
    logic      clear;
    cidx_t     bg;
    logic      clear_busy;
    logic      rot_start;
    vertex_t   rot_in;
    logic      rot_done;
    vertex_t   rot_out;
    logic      line_start;
    vertex_t   p0;
    vertex_t   p1;
    logic      line_done;
    pixel_t    pix;
    logic      pix_valid;
    logic      pix_ready;

    host_regs host_regs_inst (
        .clk_100m, .reset, .axi_req, .axi_rsp, .cfg, .start, .busy,
        .done_pulse, .irq, .rd_addr(fb_rd_addr), .rd_data(fb_rd_data)
    );

    shape_sequencer shape_sequencer_inst (
        .clk_100m, .reset, .cfg, .start, .busy, .done_pulse, .clear, .bg,
        .clear_busy, .rot_start, .rot_in, .rot_done, .rot_out,
        .line_start, .p0, .p1, .line_done
    );

    // angle and offset come straight from the host registers
    rotate_xy rotate_xy_inst (
        .clk_100m, .reset, .start(rot_start), .vin(rot_in), .angle(cfg.angle),
        .offset(cfg.offset), .vout(rot_out), .done(rot_done)
    );

    draw_line draw_line_inst (
        .clk_100m, .reset, .start(line_start), .p0, .p1,
        .pix, .pix_valid, .pix_ready, .done(line_done)
    );

    framebuffer framebuffer_inst (
        .clk_100m, .reset, .clear, .bg, .fg(cfg.fg), .clear_busy,
        .pix, .pix_valid, .pix_ready, .rd_addr(fb_rd_addr), .rd_data(fb_rd_data)
    );

endmodule

//--- logic/shape_sequencer.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// draw control: clear, rotate the three vertices, then the three edges
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module shape_sequencer (
    input  logic                clk_100m,
    input  logic                reset,
    input  host_pkg::draw_cfg_t cfg,
    input  logic                start,
    output logic                busy,
    output logic                done_pulse,
    output logic                clear,
    output gfx_pkg::cidx_t      bg,
    input  logic                clear_busy,
    output logic                rot_start,
    output gfx_pkg::vertex_t    rot_in,
    input  logic                rot_done,
    input  gfx_pkg::vertex_t    rot_out,
    output logic                line_start,
    output gfx_pkg::vertex_t    p0,
    output gfx_pkg::vertex_t    p1,
    input  logic                line_done
);
    import gfx_pkg::*;
    import host_pkg::*;

    typedef enum logic [2:0] {
        IDLE, CLEAR, ROT, ROT_WAIT, LINE0, LINE1, LINE2, DONE
    } state_t;

    state_t     state;
    draw_cfg_t  cfg_r;       // held for the whole draw
    vertex_t    rv [3];      // rotated vertices, in issue order
    logic [1:0] issue_cnt;
    logic [1:0] cap_cnt;

    assign bg = cfg_r.bg;

    always_ff @(posedge clk_100m) begin
        clear      <= 1'b0;
        rot_start  <= 1'b0;
        line_start <= 1'b0;
        done_pulse <= 1'b0;
        if (reset) begin
            state <= IDLE;
            busy  <= 1'b0;
        end else begin
            case (state)
                IDLE: if (start) begin
                    cfg_r <= cfg;
                    clear <= 1'b1;
                    busy  <= 1'b1;
                    state <= CLEAR;
                end
                // once clear_busy is up the pixel stream is held off
                CLEAR: if (clear_busy) begin
                    rot_start <= 1'b1;
                    rot_in    <= cfg_r.v0;
                    issue_cnt <= 2'd1;
                    cap_cnt   <= 2'd0;
                    state     <= ROT;
                end
                ROT: begin                                // back to back starts
                    rot_start <= 1'b1;
                    rot_in    <= (issue_cnt == 2'd1) ? cfg_r.v1 : cfg_r.v2;
                    issue_cnt <= issue_cnt + 2'd1;
                    if (issue_cnt == 2'd2)
                        state <= ROT_WAIT;
                end
                ROT_WAIT: if (rot_done) begin
                    rv[cap_cnt] <= rot_out;
                    cap_cnt     <= cap_cnt + 2'd1;
                    if (cap_cnt == 2'd2) begin
                        line_start <= 1'b1;
                        p0         <= rv[0];
                        p1         <= rv[1];
                        state      <= LINE0;
                    end
                end
                LINE0: if (line_done) begin
                    line_start <= 1'b1;
                    p0         <= rv[1];
                    p1         <= rv[2];
                    state      <= LINE1;
                end
                LINE1: if (line_done) begin
                    line_start <= 1'b1;
                    p0         <= rv[2];
                    p1         <= rv[0];
                    state      <= LINE2;
                end
                LINE2: if (line_done)
                    state <= DONE;
                DONE: begin
                    done_pulse <= 1'b1;
                    busy       <= 1'b0;
                    state      <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

//--- logic/sin_table.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// quarter-wave sine, round(127*sin(k*pi/128)) for k = 0..64, with the
// folded lookup; included inside a module body after gfx_pkg
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef SIN_TABLE_SVH
`define SIN_TABLE_SVH

localparam logic [6:0] SIN_Q [65] = '{
      0,   3,   6,   9,  12,  16,  19,  22,  25,  28,  31,
     34,  37,  40,  43,  46,  49,  51,  54,  57,  60,  63,
     65,  68,  71,  73,  76,  78,  81,  83,  85,  88,  90,
     92,  94,  96,  98, 100, 102, 104, 106, 107, 109, 111,
    112, 113, 115, 116, 117, 118, 120, 121, 122, 122, 123,
    124, 125, 125, 126, 126, 126, 127, 127, 127, 127
};

function automatic gfx_pkg::trig_t sin_lookup(input gfx_pkg::angle_t a);
    logic [5:0]     r;
    gfx_pkg::trig_t mag;
    r   = a[5:0];
    mag = gfx_pkg::trig_t'(a[6] ? SIN_Q[64 - r] : SIN_Q[r]);  // odd quadrants mirror
    return a[7] ? -mag : mag;                                  // second half negative
endfunction

`endif

//--- sim/shape_engine_properties.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pixel stream checks on the line walker, attached by bind
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module shape_engine_properties (
    input logic            clk_100m,
    input logic            reset,
    input logic            start,
    input gfx_pkg::pixel_t pix,
    input logic            pix_valid,
    input logic            pix_ready,
    input logic            done
);

    bit failed = 1'b0;   // sticky, set by any failing property

    // a stalled beat keeps its pixel
    stall_holds_pixel: assert property (@(posedge clk_100m) disable iff (reset)
        pix_valid && !pix_ready |=> pix_valid && $stable(pix))
    else begin
        $error("pixel changed or dropped while stalled");
        failed = 1'b1;
    end

    no_done_mid_stream: assert property (@(posedge clk_100m) disable iff (reset)
        done |-> !pix_valid)
    else begin
        $error("line done while a pixel is still offered");
        failed = 1'b1;
    end

    // valid only rises right after a line start
    no_pixel_outside_draw: assert property (@(posedge clk_100m) disable iff (reset)
        !pix_valid && !start |=> !pix_valid)
    else begin
        $error("pixel emitted without a line start");
        failed = 1'b1;
    end

endmodule

bind draw_line shape_engine_properties props0 (
    .clk_100m, .reset, .start, .pix, .pix_valid, .pix_ready, .done
);

//--- sim/shape_engine_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the shape engine: programs draws over AXI4-Lite and
// compares every framebuffer pixel with a software model
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module shape_engine_tb;
    import gfx_pkg::*;
    import host_pkg::*;

    localparam int NUM_DRAWS    = 23;     // restart, fixed, redraw and 20 random
    localparam int WATCHDOG_CYC = 60000 * NUM_DRAWS;

    logic      clk_100m;
    logic      reset;
    axil_req_t axi_req;
    axil_rsp_t axi_rsp;
    logic      irq;
    int        irq_count = 0;
    cidx_t     model_fb [FB_DEPTH];      // expected picture
    vertex_t   vtx [3];                  // current draw settings
    vertex_t   offs;
    int        ang;
    cidx_t     fg_idx;
    cidx_t     bg_idx;

    shape_engine_top dut0 (.clk_100m, .reset, .axi_req, .axi_rsp, .irq);

    initial begin
        clk_100m = 1'b0;
        forever #5 clk_100m = ~clk_100m;
    end

    always @(negedge clk_100m) begin
        if (irq)
            irq_count++;                 // one count per pulse
    end

    // bound line walker properties latch a flag when one of them fails
    always @(negedge clk_100m) begin
        assert (!dut0.draw_line_inst.props0.failed)
        else begin
            $display("a pixel stream assertion on the line walker failed");
            $display("FAIL: see errors above");
            $fatal(1, "bound assertion failed");
        end
    end

    initial begin
        repeat (WATCHDOG_CYC) @(posedge clk_100m);
        $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYC);
        $display("FAIL: see errors above");
        $fatal(1, "watchdog expired");
    end

    task automatic next_cycle();
        @(posedge clk_100m);
        #1;                              // inputs change just after the edge
    endtask

    task automatic stop_with_error(input string msg);
        $display("ERR %0t: %s", $time, msg);
        $display("FAIL: see errors above");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic write_reg(input axi_addr_t addr, input axi_data_t data);
        logic       hs;
        logic [1:0] resp;
        axi_req.awaddr  = addr;
        axi_req.wdata   = data;
        axi_req.wstrb   = 4'hF;
        axi_req.awvalid = 1'b1;
        axi_req.wvalid  = 1'b1;
        while (!axi_rsp.awready)
            next_cycle();
        next_cycle();                    // address and data taken here
        axi_req.awvalid = 1'b0;
        axi_req.wvalid  = 1'b0;
        do begin
            axi_req.bready = ($urandom % 4) != 0;   // random back-pressure
            hs   = axi_rsp.bvalid && axi_req.bready;
            resp = axi_rsp.bresp;
            next_cycle();
        end while (!hs);
        axi_req.bready = 1'b0;
        assert (resp == 2'b00)
        else stop_with_error($sformatf("write to %0h answered bresp %0b", addr, resp));
    endtask

    task automatic read_word(input axi_addr_t addr, output axi_data_t data);
        logic       hs;
        logic [1:0] resp;
        axi_req.araddr  = addr;
        axi_req.arvalid = 1'b1;
        while (!axi_rsp.arready)
            next_cycle();
        next_cycle();
        axi_req.arvalid = 1'b0;
        do begin
            axi_req.rready = ($urandom % 4) != 0;
            hs   = axi_rsp.rvalid && axi_req.rready;
            data = axi_rsp.rdata;
            resp = axi_rsp.rresp;
            next_cycle();
        end while (!hs);
        axi_req.rready = 1'b0;
        assert (resp == 2'b00)
        else stop_with_error($sformatf("read from %0h answered rresp %0b", addr, resp));
    endtask

    task automatic expect_reg(input axi_addr_t addr, input axi_data_t want);
        axi_data_t got;
        read_word(addr, got);
        assert (got == want)
        else stop_with_error($sformatf("register %0h read %0h, expected %0h", addr, got, want));
    endtask

    function automatic int rand_span(input int lo, input int hi);
        return lo + int'($urandom % (hi - lo + 1));
    endfunction

    function automatic vertex_t point(input int x, input int y);
        vertex_t v;
        v.x = coord_t'(x);
        v.y = coord_t'(y);
        return v;
    endfunction

    // 127 * sin(a * pi / 128), rounded to nearest
    function automatic int trig_ref(input int a);
        return int'(127.0 * $sin(3.141592653589793 * a / 128.0));
    endfunction

    function automatic vertex_t rotate_point(input vertex_t v);
        int      s;
        int      c;
        vertex_t r;
        s   = trig_ref(ang);
        c   = trig_ref(ang + 64);
        r.x = coord_t'(((v.x * c - v.y * s) >>> TRIG_SHIFT) + offs.x);
        r.y = coord_t'(((v.x * s + v.y * c) >>> TRIG_SHIFT) + offs.y);
        return r;
    endfunction

    function automatic void plot_line(input vertex_t p, input vertex_t q);
        int x;
        int y;
        int dx;
        int dy;
        int err;
        int e2;
        x   = p.x;
        y   = p.y;
        dx  = (q.x > p.x) ? q.x - p.x : p.x - q.x;
        dy  = (q.y > p.y) ? p.y - q.y : q.y - p.y;   // minus |dy|
        err = dx + dy;
        forever begin
            if (x >= 0 && x < FB_SIDE && y >= 0 && y < FB_SIDE)
                model_fb[y * FB_SIDE + x] = fg_idx;   // clipped plot
            if (x == q.x && y == q.y)
                break;
            e2 = 2 * err;
            if (e2 >= dy) begin
                err += dy;
                x   += (q.x > p.x) ? 1 : -1;
            end
            if (e2 <= dx) begin
                err += dx;
                y   += (q.y > p.y) ? 1 : -1;
            end
        end
    endfunction

    function automatic void model_draw();
        vertex_t r [3];
        for (int i = 0; i < FB_DEPTH; i++)
            model_fb[i] = bg_idx;
        for (int i = 0; i < 3; i++)
            r[i] = rotate_point(vtx[i]);
        plot_line(r[0], r[1]);
        plot_line(r[1], r[2]);
        plot_line(r[2], r[0]);
    endfunction

    task automatic randomize_config();
        ang    = rand_span(0, 255);
        offs   = point(rand_span(0, 63), rand_span(0, 63));
        for (int i = 0; i < 3; i++)
            vtx[i] = point(rand_span(-40, 40), rand_span(-40, 40));
        fg_idx = cidx_t'(rand_span(0, 15));
        bg_idx = fg_idx + cidx_t'(rand_span(1, 15));  // never the same as fg
    endtask

    task automatic write_config();
        write_reg(REG_ANGLE, ang);
        write_reg(REG_OFFSET, offs);
        write_reg(REG_V0, vtx[0]);
        write_reg(REG_V1, vtx[1]);
        write_reg(REG_V2, vtx[2]);
        write_reg(REG_COLOUR, {bg_idx, fg_idx});
    endtask

    task automatic check_frame(input string what);
        axi_data_t got;
        for (int a = 0; a < FB_DEPTH; a++) begin
            read_word(FB_BASE + axi_addr_t'(4 * a), got);
            assert (got == {28'd0, model_fb[a]})
            else stop_with_error($sformatf("%s: pixel (%0d,%0d) read %0h, expected %0h",
                what, a % FB_SIDE, a / FB_SIDE, got, model_fb[a]));
        end
    endtask

    task automatic run_draw(input bit restart, input string what);
        int        irq_before;
        axi_data_t st;
        write_config();
        model_draw();
        irq_before = irq_count;
        write_reg(REG_CTRL, 32'd1);
        if (restart) begin
            expect_reg(REG_STATUS, 32'h1);   // busy, done cleared
            write_reg(REG_CTRL, 32'd1);      // ignored while busy
        end
        do
            read_word(REG_STATUS, st);
        while (!st[1]);
        assert (!st[0]) else stop_with_error($sformatf("%s: busy still set with done", what));
        check_frame(what);
        assert (irq_count == irq_before + 1)
        else stop_with_error($sformatf("%s: %0d irq pulses, expected one",
            what, irq_count - irq_before));
    endtask

    initial begin
        void'($urandom(32'h17bc));
        axi_req = '0;
        reset   = 1'b1;
        repeat (8) next_cycle();
        assert (!axi_rsp.awready && !axi_rsp.wready && !axi_rsp.bvalid && !axi_rsp.arready
                && !axi_rsp.rvalid && !irq)
        else stop_with_error("AXI handshake outputs or irq not low in reset");
        reset = 1'b0;
        expect_reg(REG_STATUS, 32'h0);

        randomize_config();
        write_config();
        expect_reg(REG_ANGLE, ang);
        expect_reg(REG_OFFSET, offs);
        expect_reg(REG_V0, vtx[0]);
        expect_reg(REG_V1, vtx[1]);
        expect_reg(REG_V2, vtx[2]);
        expect_reg(REG_COLOUR, {bg_idx, fg_idx});
        run_draw(1'b1, "restart while busy");

        // upright triangle around the centre
        ang    = 0;
        offs   = point(32, 32);
        vtx[0] = point(-20, -15);
        vtx[1] = point(25, -10);
        vtx[2] = point(0, 22);
        fg_idx = 4'hA;
        bg_idx = 4'h1;
        run_draw(1'b0, "angle zero");

        // new shape and bg, old outline must be gone
        vtx[0] = point(-30, 5);
        vtx[1] = point(10, -28);
        vtx[2] = point(18, 26);
        bg_idx = 4'h6;
        run_draw(1'b0, "redraw");

        repeat (20) begin
            randomize_config();
            run_draw(1'b0, "random draw");
        end

        $display("PASS: all tests");
        $finish;
    end

endmodule
